/* dh_pkg.sv */
/*
 * Fixed-point types, register map and shared constants for the DH kinematics core.
 * Every RTL module and the testbench import what they need from here.
 */
`default_nettype none

package dh_pkg;

	typedef logic signed [26:0] fix_t;	// Q10.16
	typedef logic [15:0] angle_t;	// Fraction of a full turn

	typedef struct packed {
		angle_t alpha;
		angle_t theta;
		fix_t a;
		fix_t d;
	} dh_param_t;

	typedef fix_t [11:0] mat34_t;	// Entry row*4+col, bottom row implied

	typedef logic [2:0] link_tag_t;
	typedef logic [5:0] chain_tag_t;	// {row, col, term}

	localparam fix_t FIX_ONE = 27'sd65536;
	localparam int MUL_LAT = 2;

	localparam logic [11:0] REG_ALPHA = 12'h000;
	localparam logic [11:0] REG_THETA = 12'h004;
	localparam logic [11:0] REG_A = 12'h008;
	localparam logic [11:0] REG_D = 12'h00C;
	localparam logic [11:0] REG_CTRL = 12'h010;
	localparam logic [11:0] REG_STATUS = 12'h014;
	localparam logic [11:0] REG_RES0 = 12'h040;

endpackage

`default_nettype wire

/* dh_mul_if.sv */
/*
 * One requester's connection to the shared multiplier.
 * Request side holds req, a, b and tag until it samples gnt; the product
 * returns MUL_LAT cycles after the grant with rvalid and the same tag.
 */
`timescale 1ns/1ps
`default_nettype none

interface dh_mul_if
	import dh_pkg::*;
#(
	parameter type tag_t = link_tag_t
);

	logic req;
	fix_t a;
	fix_t b;
	tag_t tag;
	logic gnt;
	logic rvalid;
	tag_t rtag;
	logic signed [2*$bits(fix_t)-1:0] result;	// Full product, 32 fraction bits

	modport req_mp (output req, a, b, tag, input gnt, rvalid, rtag, result);
	modport arb_mp (input req, a, b, tag, output gnt, rvalid, rtag, result);

endinterface

`default_nettype wire

/* sincos_cordic.sv */
/*
 * Iterative rotation-mode CORDIC, one step per clock.
 * Pulse i_start with an angle; o_sin and o_cos are valid with o_done and
 * stay put until the next start.
 */
`timescale 1ns/1ps
`default_nettype none

module sincos_cordic
	import dh_pkg::*;
#(
	parameter int CORDIC_ITER = 16
) (
	input wire i,
	input wire i_rst_n,
	input wire i_start,
	input wire angle_t i_angle,
	output fix_t o_sin,
	output fix_t o_cos,
	output logic o_done
);

	localparam int IW = $clog2(CORDIC_ITER + 1);
	localparam fix_t K_INV = 27'sd39797;	// 1/gain

	typedef logic signed [20:0] zang_t;	// Turn scaled by 2^20

	function automatic zang_t atan_turn(logic [IW-1:0] k);
		case (k)
			0: return 21'sd131072;
			1: return 21'sd77376;
			2: return 21'sd40884;
			3: return 21'sd20753;
			4: return 21'sd10417;
			5: return 21'sd5213;
			6: return 21'sd2607;
			7: return 21'sd1304;
			8: return 21'sd652;
			9: return 21'sd326;
			10: return 21'sd163;
			11: return 21'sd81;
			12: return 21'sd41;
			13: return 21'sd20;
			14: return 21'sd10;
			15: return 21'sd5;
			default: return '0;
		endcase
	endfunction

	logic run_q;
	logic [IW-1:0] it_q;
	logic [1:0] quad_q;
	fix_t x_q;
	fix_t y_q;
	zang_t z_q;
	fix_t x_sh;
	fix_t y_sh;
	logic last;

	assign x_sh = x_q >>> it_q;
	assign y_sh = y_q >>> it_q;
	assign last = run_q && (it_q == IW'(CORDIC_ITER));

	always_ff @(posedge i) begin
		if (!i_rst_n) begin
			run_q <= 1'b0;
			it_q <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= last;
			if (i_start) begin
				run_q <= 1'b1;
				it_q <= '0;
			end else if (last) begin
				run_q <= 1'b0;
			end else if (run_q) begin
				it_q <= it_q + 1'b1;
			end
		end
	end

	always_ff @(posedge i) begin
		if (i_start) begin
			quad_q <= i_angle[15:14];
			x_q <= K_INV;
			y_q <= '0;
			z_q <= zang_t'({3'b000, i_angle[13:0], 4'b0000});	// First quadrant residue
		end else if (run_q && !last) begin
			if (!z_q[20]) begin
				x_q <= x_q - y_sh;
				y_q <= y_q + x_sh;
				z_q <= z_q - atan_turn(it_q);
			end else begin
				x_q <= x_q + y_sh;
				y_q <= y_q - x_sh;
				z_q <= z_q + atan_turn(it_q);
			end
		end
		if (last) begin
			case (quad_q)
				2'd0: begin
					o_sin <= y_q;
					o_cos <= x_q;
				end
				2'd1: begin
					o_sin <= x_q;
					o_cos <= -y_q;
				end
				2'd2: begin
					o_sin <= -y_q;
					o_cos <= -x_q;
				end
				default: begin
					o_sin <= -x_q;
					o_cos <= y_q;
				end
			endcase
		end
	end

	a_done_pulse: assert property (@(posedge i) disable iff (!i_rst_n) o_done |=> !o_done);

endmodule

`default_nettype wire

/* dh_link_matrix.sv */
/*
 * Builds one DH link transform from alpha, theta, a and d.
 * Two CORDIC units give the sines and cosines; the six cross products go
 * through the shared multiplier. The matrix is held until i_lready.
 */
`timescale 1ns/1ps
`default_nettype none

module dh_link_matrix
	import dh_pkg::*;
#(
	parameter int CORDIC_ITER = 16
) (
	input wire i,
	input wire i_rst_n,
	input wire i_push,
	input wire dh_param_t i_param,
	input wire i_lready,
	output logic o_busy,
	output logic o_lvalid,
	output mat34_t o_link,
	dh_mul_if.req_mp mul
);

	typedef enum logic [1:0] {S_IDLE, S_TRIG, S_MUL, S_HOLD} state_t;

	state_t state_q;
	fix_t sin_a;
	fix_t cos_a;
	fix_t sin_t;
	fix_t cos_t;
	logic done_a;
	logic done_t;
	logic start;
	logic trig_done;
	fix_t a_q;
	fix_t d_q;
	logic [2:0] iss_q;
	logic [2:0] ret_q;
	mat34_t link_q;

	// Tags 0..2 land in row 0, 3..5 in row 1, skipping column 0
	function automatic logic [3:0] entry_of(link_tag_t t);
		return (t < 3'd3) ? 4'(t) + 4'd1 : 4'(t) + 4'd2;
	endfunction

	assign start = i_push && (state_q == S_IDLE);
	assign trig_done = (state_q == S_TRIG) && done_a && done_t;

	sincos_cordic #(.CORDIC_ITER(CORDIC_ITER)) u_cs_alpha (
		.i(i),
		.i_rst_n(i_rst_n),
		.i_start(start),
		.i_angle(i_param.alpha),
		.o_sin(sin_a),
		.o_cos(cos_a),
		.o_done(done_a)
	);

	sincos_cordic #(.CORDIC_ITER(CORDIC_ITER)) u_cs_theta (
		.i(i),
		.i_rst_n(i_rst_n),
		.i_start(start),
		.i_angle(i_param.theta),
		.o_sin(sin_t),
		.o_cos(cos_t),
		.o_done(done_t)
	);

	assign mul.req = (state_q == S_MUL) && (iss_q < 3'd6);
	assign mul.tag = link_tag_t'(iss_q);

	always_comb begin
		mul.a = '0;
		mul.b = '0;
		case (iss_q)
			3'd0: begin
				mul.a = -sin_t;
				mul.b = cos_a;
			end
			3'd1: begin
				mul.a = sin_t;
				mul.b = sin_a;
			end
			3'd2: begin
				mul.a = a_q;
				mul.b = cos_t;
			end
			3'd3: begin
				mul.a = cos_t;
				mul.b = cos_a;
			end
			3'd4: begin
				mul.a = -cos_t;
				mul.b = sin_a;
			end
			3'd5: begin
				mul.a = a_q;
				mul.b = sin_t;
			end
			default: ;
		endcase
	end

	always_ff @(posedge i) begin
		if (!i_rst_n) begin
			state_q <= S_IDLE;
			iss_q <= '0;
			ret_q <= '0;
		end else begin
			case (state_q)
				S_IDLE: if (start) state_q <= S_TRIG;
				S_TRIG: begin
					if (trig_done) begin
						state_q <= S_MUL;
						iss_q <= '0;
						ret_q <= '0;
					end
				end
				S_MUL: begin
					if (mul.gnt) iss_q <= iss_q + 3'd1;
					if (mul.rvalid) ret_q <= ret_q + 3'd1;
					if (mul.rvalid && ret_q == 3'd5) state_q <= S_HOLD;
				end
				default: if (i_lready) state_q <= S_IDLE;	// Chain took the matrix
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (start) begin
			a_q <= i_param.a;
			d_q <= i_param.d;
		end
		if (trig_done) begin
			link_q[0] <= cos_t;
			link_q[4] <= sin_t;
			link_q[8] <= '0;
			link_q[9] <= sin_a;
			link_q[10] <= cos_a;
			link_q[11] <= d_q;
		end
		if (mul.rvalid) link_q[entry_of(mul.rtag)] <= fix_t'(mul.result[16 +: $bits(fix_t)]);
	end

	assign o_busy = (state_q != S_IDLE);
	assign o_lvalid = (state_q == S_HOLD);
	assign o_link = link_q;

endmodule

`default_nettype wire

/* dh_chain.sv */
/*
 * Chain accumulator: acc = acc * link for each link handed over.
 * The 36 products go through the shared multiplier, tagged {row, col, term};
 * the new transform replaces acc once all of them are back.
 */
`timescale 1ns/1ps
`default_nettype none

module dh_chain
	import dh_pkg::*;
(
	input wire i,
	input wire i_rst_n,
	input wire i_lvalid,
	input wire mat34_t i_link,
	input wire i_clear,
	output logic o_lready,
	output logic o_busy,
	output mat34_t o_acc,
	dh_mul_if.req_mp mul
);

	logic busy_q;
	logic accept;
	logic [1:0] row_q;
	logic [1:0] col_q;
	logic [1:0] term_q;
	logic [5:0] ret_q;
	mat34_t acc_q;
	mat34_t lnk_q;
	mat34_t sum_q;

	function automatic mat34_t identity();
		mat34_t m;
		m = '0;
		m[0] = FIX_ONE;
		m[5] = FIX_ONE;
		m[10] = FIX_ONE;
		return m;
	endfunction

	assign accept = i_lvalid && !busy_q;

	assign mul.req = busy_q && (row_q != 2'd3);	// Row 3 means all issued
	assign mul.a = acc_q[{row_q, term_q}];
	assign mul.b = lnk_q[{term_q, col_q}];
	assign mul.tag = {row_q, col_q, term_q};

	always_ff @(posedge i) begin
		if (!i_rst_n) begin
			busy_q <= 1'b0;
			row_q <= '0;
			col_q <= '0;
			term_q <= '0;
			ret_q <= '0;
			acc_q <= identity();
		end else begin
			if (accept) begin
				busy_q <= 1'b1;
				row_q <= '0;
				col_q <= '0;
				term_q <= '0;
				ret_q <= '0;
			end else if (busy_q) begin
				if (mul.gnt) begin
					if (term_q == 2'd2) begin
						term_q <= '0;
						col_q <= col_q + 2'd1;
						if (col_q == 2'd3) row_q <= row_q + 2'd1;
					end else begin
						term_q <= term_q + 2'd1;
					end
				end
				if (mul.rvalid) ret_q <= ret_q + 6'd1;
				if (ret_q == 6'd36) begin
					busy_q <= 1'b0;
					acc_q <= sum_q;
				end
			end
			if (i_clear) acc_q <= identity();
		end
	end

	always_ff @(posedge i) begin
		if (accept) begin
			lnk_q <= i_link;
			for (int k = 0; k < 12; k++) begin
				sum_q[k] <= (k % 4 == 3) ? acc_q[k] : '0;	// Old translation, once per row
			end
		end
		if (mul.rvalid) begin
			sum_q[mul.rtag[5:2]] <= sum_q[mul.rtag[5:2]]
				+ fix_t'(mul.result[16 +: $bits(fix_t)]);
		end
	end

	assign o_lready = accept;
	assign o_busy = busy_q;
	assign o_acc = acc_q;

endmodule

`default_nettype wire

/* dh_mul_arbiter.sv */
/*
 * Round-robin arbiter in front of one pipelined signed 27x27 multiplier.
 * Each product is routed back to the port that won the grant, with its tag.
 */
`timescale 1ns/1ps
`default_nettype none

module dh_mul_arbiter
	import dh_pkg::*;
#(
	parameter type tag0_t = link_tag_t,
	parameter type tag1_t = chain_tag_t
) (
	input wire i,
	input wire i_rst_n,
	dh_mul_if.arb_mp mul0,
	dh_mul_if.arb_mp mul1
);

	localparam int PW = 2 * $bits(fix_t);

	logic gnt0;
	logic gnt1;
	logic last1_q;	// Port 1 won the last grant
	logic [MUL_LAT-1:0] vld_q;
	logic [MUL_LAT-1:0] sel_q;
	tag0_t tag0_q [MUL_LAT];
	tag1_t tag1_q [MUL_LAT];
	fix_t opa_q;
	fix_t opb_q;
	logic signed [PW-1:0] prod_q [MUL_LAT-1];

	assign gnt0 = mul0.req && (!mul1.req || last1_q);
	assign gnt1 = mul1.req && !gnt0;
	assign mul0.gnt = gnt0;
	assign mul1.gnt = gnt1;

	always_ff @(posedge i) begin
		if (!i_rst_n) begin
			last1_q <= 1'b0;
			vld_q <= '0;
			sel_q <= '0;
		end else begin
			if (gnt0 || gnt1) last1_q <= gnt1;
			vld_q <= {vld_q[MUL_LAT-2:0], gnt0 | gnt1};
			sel_q <= {sel_q[MUL_LAT-2:0], gnt1};
		end
	end

	always_ff @(posedge i) begin
		opa_q <= gnt1 ? mul1.a : mul0.a;
		opb_q <= gnt1 ? mul1.b : mul0.b;
		tag0_q[0] <= mul0.tag;
		tag1_q[0] <= mul1.tag;
		for (int k = 1; k < MUL_LAT; k++) begin
			tag0_q[k] <= tag0_q[k-1];
			tag1_q[k] <= tag1_q[k-1];
		end
		prod_q[0] <= opa_q * opb_q;
		for (int k = 1; k < MUL_LAT - 1; k++) begin
			prod_q[k] <= prod_q[k-1];
		end
	end

	assign mul0.rvalid = vld_q[MUL_LAT-1] && !sel_q[MUL_LAT-1];
	assign mul0.rtag = tag0_q[MUL_LAT-1];
	assign mul0.result = prod_q[MUL_LAT-2];
	assign mul1.rvalid = vld_q[MUL_LAT-1] && sel_q[MUL_LAT-1];
	assign mul1.rtag = tag1_q[MUL_LAT-1];
	assign mul1.result = prod_q[MUL_LAT-2];

	// Requesters keep the same request until granted
	a_req_held0: assert property (@(posedge i) disable iff (!i_rst_n)
		mul0.req && !mul0.gnt |=> mul0.req && $stable(mul0.tag));
	a_req_held1: assert property (@(posedge i) disable iff (!i_rst_n)
		mul1.req && !mul1.gnt |=> mul1.req && $stable(mul1.tag));

endmodule

`default_nettype wire

/* dh_apb_regs.sv */
/*
 * APB slave with the link parameter, control, status and result registers.
 * A CTRL write raises a one-cycle push or clear toward the datapath.
 */
`timescale 1ns/1ps
`default_nettype none

module dh_apb_regs
	import dh_pkg::*;
(
	input wire i,
	input wire i_rst_n,
	input wire i_psel,
	input wire i_penable,
	input wire i_pwrite,
	input wire [11:0] i_paddr,
	input wire [31:0] i_pwdata,
	input wire i_link_busy,
	input wire i_chain_busy,
	input wire mat34_t i_acc,
	output logic [31:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,
	output logic o_push,
	output dh_param_t o_param,
	output logic o_acc_clear
);

	logic access;
	logic wr;
	logic hit_res;
	logic mapped;
	logic push_req;
	logic link_busy;
	logic [3:0] res_idx;
	angle_t alpha_q;
	angle_t theta_q;
	fix_t a_q;
	fix_t d_q;

	assign access = i_psel && i_penable;
	assign wr = access && i_pwrite;
	assign res_idx = i_paddr[5:2];
	assign hit_res = (i_paddr[11:6] == REG_RES0[11:6]) && (res_idx < 4'd12)
		&& (i_paddr[1:0] == 2'd0);
	assign mapped = hit_res || (i_paddr == REG_ALPHA) || (i_paddr == REG_THETA)
		|| (i_paddr == REG_A) || (i_paddr == REG_D) || (i_paddr == REG_CTRL)
		|| (i_paddr == REG_STATUS);
	assign link_busy = i_link_busy || o_push;	// Covers the push in flight
	assign push_req = wr && (i_paddr == REG_CTRL) && i_pwdata[0];

	assign o_pready = 1'b1;
	assign o_pslverr = access && (!mapped || (push_req && link_busy));

	always_comb begin
		o_prdata = '0;
		case (i_paddr)
			REG_ALPHA: o_prdata = {16'd0, alpha_q};
			REG_THETA: o_prdata = {16'd0, theta_q};
			REG_A: o_prdata = {{5{a_q[26]}}, a_q};
			REG_D: o_prdata = {{5{d_q[26]}}, d_q};
			REG_STATUS: o_prdata = {30'd0, i_chain_busy, link_busy};
			default: if (hit_res) o_prdata = {{5{i_acc[res_idx][26]}}, i_acc[res_idx]};
		endcase
	end

	always_ff @(posedge i) begin
		if (!i_rst_n) begin
			o_push <= 1'b0;
			o_acc_clear <= 1'b0;
		end else begin
			o_push <= push_req && !link_busy;
			o_acc_clear <= wr && (i_paddr == REG_CTRL) && i_pwdata[1];
		end
	end

	always_ff @(posedge i) begin
		if (wr && i_paddr == REG_ALPHA) alpha_q <= i_pwdata[15:0];
		if (wr && i_paddr == REG_THETA) theta_q <= i_pwdata[15:0];
		if (wr && i_paddr == REG_A) a_q <= i_pwdata[26:0];
		if (wr && i_paddr == REG_D) d_q <= i_pwdata[26:0];
	end

	assign o_param = '{alpha: alpha_q, theta: theta_q, a: a_q, d: d_q};

	a_push_idle: assert property (@(posedge i) disable iff (!i_rst_n)
		o_push |-> !i_link_busy);

endmodule

`default_nettype wire

/* dh_kin_top.sv */
/*
 * Forward-kinematics subsystem top level with a single APB slave port.
 * Link builder and chain accumulator share one multiplier through the arbiter.
 */
`timescale 1ns/1ps
`default_nettype none

module dh_kin_top
	import dh_pkg::*;
#(
	parameter int CORDIC_ITER = 16
) (
	input wire i,
	input wire i_rst_n,
	input wire i_psel,
	input wire i_penable,
	input wire i_pwrite,
	input wire [11:0] i_paddr,
	input wire [31:0] i_pwdata,
	output logic [31:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr
);

	logic push;
	logic acc_clear;
	logic link_busy;
	logic chain_busy;
	logic lvalid;
	logic lready;
	dh_param_t param;
	mat34_t link_m;
	mat34_t acc;

	dh_mul_if #(.tag_t(link_tag_t)) link_mul ();
	dh_mul_if #(.tag_t(chain_tag_t)) chain_mul ();

	dh_apb_regs u_regs (
		.i(i),
		.i_rst_n(i_rst_n),
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_pwrite(i_pwrite),
		.i_paddr(i_paddr),
		.i_pwdata(i_pwdata),
		.i_link_busy(link_busy),
		.i_chain_busy(chain_busy),
		.i_acc(acc),
		.o_prdata(o_prdata),
		.o_pready(o_pready),
		.o_pslverr(o_pslverr),
		.o_push(push),
		.o_param(param),
		.o_acc_clear(acc_clear)
	);

	dh_link_matrix #(.CORDIC_ITER(CORDIC_ITER)) u_link (
		.i(i),
		.i_rst_n(i_rst_n),
		.i_push(push),
		.i_param(param),
		.i_lready(lready),
		.o_busy(link_busy),
		.o_lvalid(lvalid),
		.o_link(link_m),
		.mul(link_mul.req_mp)
	);

	dh_chain u_chain (
		.i(i),
		.i_rst_n(i_rst_n),
		.i_lvalid(lvalid),
		.i_link(link_m),
		.i_clear(acc_clear),
		.o_lready(lready),
		.o_busy(chain_busy),
		.o_acc(acc),
		.mul(chain_mul.req_mp)
	);

	dh_mul_arbiter #(.tag0_t(link_tag_t), .tag1_t(chain_tag_t)) u_arb (
		.i(i),
		.i_rst_n(i_rst_n),
		.mul0(link_mul.arb_mp),
		.mul1(chain_mul.arb_mp)
	);

endmodule

`default_nettype wire

/* tb_dh_kin.sv */
/*
 * Testbench for the DH kinematics subsystem. Replays APB writes, status polls
 * and result checks listed in dh_kin_tests.txt against the top level.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dh_kin
	import dh_pkg::*;
();

	localparam int TEST_WORDS = 384;
	localparam int DRV_NS = 1;	// Drive delay after the rising edge
	localparam int APB_TIMEOUT = 20;	// Cycles to wait for o_pready
	localparam int POLL_LIMIT = 400;
	localparam int FIX_TOL = 64;

	logic i;
	logic i_rst_n;
	logic i_psel;
	logic i_penable;
	logic i_pwrite;
	logic [11:0] i_paddr;
	logic [31:0] i_pwdata;
	logic [31:0] o_prdata;
	logic o_pready;
	logic o_pslverr;

	logic [31:0] tests_mem [0:TEST_WORDS-1];	// Records of op, address, data
	int n_checks;

	dh_kin_top #(.CORDIC_ITER(16)) u_dut (
		.i(i),
		.i_rst_n(i_rst_n),
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_pwrite(i_pwrite),
		.i_paddr(i_paddr),
		.i_pwdata(i_pwdata),
		.o_prdata(o_prdata),
		.o_pready(o_pready),
		.o_pslverr(o_pslverr)
	);

	initial begin
		i = 1'b0;
		forever #50 i = ~i;
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_fix(input logic [11:0] addr, input fix_t got, input fix_t exp);
		int diff;
		diff = int'(got) - int'(exp);
		n_checks++;
		if (diff > FIX_TOL || diff < -FIX_TOL) begin
			stop_run($sformatf("error at %0d ns: word 0x%03h read %0d, expected %0d",
				$time, addr, got, exp));
		end
	endtask

	task automatic check_err(input logic [11:0] addr, input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("error at %0d ns: o_pslverr %0b at address 0x%03h, expected %0b",
				$time, got, addr, exp));
		end
	endtask

	// Starts and ends a small delay after a rising edge
	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
		output logic slverr);
		int waited;
		waited = 0;
		i_psel = 1'b1;
		i_penable = 1'b0;
		i_pwrite = 1'b1;
		i_paddr = addr;
		i_pwdata = data;
		@(posedge i);
		#(DRV_NS);
		i_penable = 1'b1;
		@(negedge i);
		while (!o_pready) begin
			waited++;
			if (waited > APB_TIMEOUT) begin
				stop_run($sformatf("APB write to 0x%03h never saw o_pready", addr));
			end
			@(negedge i);
		end
		slverr = o_pslverr;	// Settled half a cycle before the edge
		@(posedge i);
		#(DRV_NS);
		i_psel = 1'b0;
		i_penable = 1'b0;
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
		output logic slverr);
		int waited;
		waited = 0;
		i_psel = 1'b1;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = addr;
		@(posedge i);
		#(DRV_NS);
		i_penable = 1'b1;
		@(negedge i);
		while (!o_pready) begin
			waited++;
			if (waited > APB_TIMEOUT) begin
				stop_run($sformatf("APB read of 0x%03h never saw o_pready", addr));
			end
			@(negedge i);
		end
		data = o_prdata;
		slverr = o_pslverr;
		@(posedge i);
		#(DRV_NS);
		i_psel = 1'b0;
		i_penable = 1'b0;
	endtask

	task automatic wait_status_clear(input logic [31:0] mask);
		logic [31:0] status;
		logic slverr;
		int polls;
		polls = 0;
		apb_read(REG_STATUS, status, slverr);
		check_err(REG_STATUS, slverr, 1'b0);
		while ((status & mask) != 32'd0) begin
			polls++;
			if (polls > POLL_LIMIT) begin
				stop_run($sformatf("Status bits 0x%0h still busy after %0d polls",
					status & mask, polls));
			end
			apb_read(REG_STATUS, status, slverr);
			check_err(REG_STATUS, slverr, 1'b0);
		end
	endtask

	initial begin
		int pc;
		logic [31:0] op;
		logic [11:0] addr;
		logic [31:0] data;
		logic [31:0] rdata;
		logic slverr;
		i_rst_n = 1'b0;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		n_checks = 0;
		pc = 0;
		$readmemh("dh_kin_tests.txt", tests_mem);
		repeat (3) @(posedge i);
		#(DRV_NS);
		i_rst_n = 1'b1;
		while (pc + 2 < TEST_WORDS && tests_mem[pc] !== 32'd0) begin
			op = tests_mem[pc];
			addr = tests_mem[pc+1][11:0];
			data = tests_mem[pc+2];
			case (op)
				32'd1: begin
					apb_write(addr, data, slverr);
					check_err(addr, slverr, 1'b0);
				end
				32'd2: wait_status_clear(data);
				32'd3: begin
					apb_read(addr, rdata, slverr);
					check_err(addr, slverr, 1'b0);
					check_fix(addr, fix_t'(rdata[26:0]), fix_t'(data[26:0]));
				end
				32'd4: begin
					apb_write(addr, data, slverr);
					check_err(addr, slverr, 1'b1);	// Refused write
				end
				default: begin
					stop_run($sformatf("Unknown operation %0h at word %0d of the test file",
						op, pc));
				end
			endcase
			pc += 3;
		end
		if (n_checks > 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			stop_run("No result checks ran, the test file is missing or empty");
		end
	end

endmodule

`default_nettype wire

/* dh_kin.f */
dh_pkg.sv
dh_mul_if.sv
sincos_cordic.sv
dh_link_matrix.sv
dh_chain.sv
dh_mul_arbiter.sv
dh_apb_regs.sv
dh_kin_top.sv
tb_dh_kin.sv

/* Makefile */
sim:
	verilator --binary --timing --assert -j 0 --top-module tb_dh_kin -f dh_kin.f
	./obj_dir/Vtb_dh_kin

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* dh_kin_tests.txt */
// op addr data: 1 write, 2 poll STATUS until (status & data) is 0, 3 check result
// word against data (Q16, 64 LSB), 4 write that must get o_pslverr, 0 ends the list
3 040 00010000
3 044 00000000
3 04C 00000000
3 054 00010000
3 068 00010000
// Zero angles, a = 2.0, d = 0.5
1 000 00000000
1 004 00000000
1 008 00020000
1 00C 00008000
1 010 00000001
2 014 00000003
3 040 00010000
3 044 00000000
3 04C 00020000
3 054 00010000
3 05C 00000000
3 068 00010000
3 06C 00008000
// Clear, then theta a quarter turn, a = 1.0, d = 2.0
1 010 00000002
1 004 00004000
1 008 00010000
1 00C 00020000
1 010 00000001
2 014 00000003
3 040 00000000
3 044 FFFF0000
3 04C 00000000
3 050 00010000
3 054 00000000
3 05C 00010000
3 068 00010000
3 06C 00020000
// Two links, second pushed while the chain works on the first
1 010 00000002
1 004 00004000
1 00C 00000000
1 010 00000001
2 014 00000001
1 000 00004000
1 004 00000000
1 00C 00008000
1 010 00000001
2 014 00000003
3 040 00000000
3 048 00010000
3 050 00010000
3 05C 00020000
3 064 00010000
3 06C 00008000
// Theta 45 degrees, refused push of 90 degrees, unmapped write
1 010 00000002
1 000 00000000
1 004 00002000
1 00C 00000000
1 010 00000001
1 004 00004000
4 010 00000001
4 020 00000000
2 014 00000003
3 040 0000B505
3 044 FFFF4AFB
3 04C 0000B505
3 050 0000B505
3 054 0000B505
3 05C 0000B505
// Clear over a non-identity transform, theta 180, alpha 270, a = 0.5, d = 1.5
1 010 00000002
1 000 0000C000
1 004 00008000
1 008 00008000
1 00C 00018000
1 010 00000001
2 014 00000003
3 040 FFFF0000
3 044 00000000
3 04C FFFF8000
3 058 FFFF0000
3 064 FFFF0000
3 06C 00018000
0 000 00000000
